//--- filelist.f
hw/rv32_types_pkg.sv
hw/mem_sys_pkg.sv
hw/dbus_if.sv
hw/lane_unit.sv
hw/load_extender.sv
hw/fence_ctrl.sv
hw/flush_timer.sv
hw/data_ram.sv
hw/mem_stage.sv
hw/mem_subsys_top.sv
tests/tb_mem_subsys.sv

//--- Makefile
# Verilator build and run of the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- tests/tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;

    localparam int CLK_PERIOD  = 40;
    localparam int WORD_ROUNDS = 8;
    localparam int LANE_OPS    = 21;
    localparam int DFLUSH      = int'(mem_sys_pkg::DCACHE_FLUSH_CYCLES);
    // Bus accesses take two cycles each, misaligned and select-only steps one
    localparam int ACCESSES    = 2 * WORD_ROUNDS + 2 * LANE_OPS + 2;
    localparam int RUN_CYCLES  = 10 + 2 * ACCESSES + 19 + 2 * (DFLUSH + 11);

    logic CLK = 1'b0;
    logic nRST;
    logic valid, dren, dwen, reg_write, ifence;
    rv32_types_pkg::ls_width_t width;
    rv32_types_pkg::word_t     alu_out, store_src, pc4, imm_u, reg_wdata;
    mem_sys_pkg::wsel_t        w_sel;
    rv32_types_pkg::reg_addr_t rd, rd_m;
    logic mem_busy, fence_stall, mal_l, mal_s, reg_write_m;

    // Expected responses, updated together with the inputs
    rv32_types_pkg::word_t exp_wdata = '0;
    rv32_types_pkg::reg_addr_t exp_rd = '0;
    logic chk_wdata       = 1'b0;
    logic exp_mal_l       = 1'b0;
    logic exp_mal_s       = 1'b0;
    logic exp_reg_write_m = 1'b0;
    int   acc_id          = 0;
    int   stall_run       = 0;

    // Byte image of the scratchpad
    logic [7:0] shadow [4 * mem_sys_pkg::MEM_WORDS];

    mem_subsys_top dut (.*);

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    // Stall cycles counted up to the previous edge
    always @(posedge CLK) begin
        stall_run <= fence_stall ? stall_run + 1 : 0;
    end

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] got);
        stop_on_failure($sformatf("error %s expected 0x%08h got 0x%08h", name, expected, got));
    endtask

    function automatic logic misaligned_access(input rv32_types_pkg::ls_width_t w,
                                               input logic [1:0] off);
        return (w == rv32_types_pkg::LW && off != 2'b00) ||
               ((w == rv32_types_pkg::LH || w == rv32_types_pkg::LHU) && off[0]);
    endfunction

    function automatic rv32_types_pkg::word_t expected_load(input rv32_types_pkg::ls_width_t w,
                                                            input logic [9:0] a);
        logic [7:0]  b;
        logic [15:0] h;
        b = shadow[a];
        h = {shadow[a + 10'd1], shadow[a]};
        case (w)
            rv32_types_pkg::LB:  return {{24{b[7]}}, b};
            rv32_types_pkg::LBU: return {24'h0, b};
            rv32_types_pkg::LH:  return {{16{h[15]}}, h};
            rv32_types_pkg::LHU: return {16'h0, h};
            default:             return {shadow[a + 10'd3], shadow[a + 10'd2], h};
        endcase
    endfunction

    // Only the bytes the access covers, low byte at the lowest address
    task automatic shadow_store(input rv32_types_pkg::ls_width_t w, input logic [9:0] a,
                                input rv32_types_pkg::word_t d);
        int n;
        n = (w == rv32_types_pkg::LB) ? 1 : (w == rv32_types_pkg::LH) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            shadow[a + 10'(i)] = d[8*i +: 8];
        end
    endtask

    task automatic drive_op(input logic v, input logic rd_en, input logic wr_en,
                            input rv32_types_pkg::ls_width_t w,
                            input rv32_types_pkg::word_t addr, input rv32_types_pkg::word_t data,
                            input mem_sys_pkg::wsel_t sel, input logic check,
                            input rv32_types_pkg::word_t expected);
        logic mis;
        rv32_types_pkg::reg_addr_t rd_val;
        mis = v && misaligned_access(w, addr[1:0]);
        rd_val = 5'($urandom);
        @(posedge CLK);
        valid           <= v;
        dren            <= rd_en;
        dwen            <= wr_en;
        width           <= w;
        alu_out         <= addr;
        store_src       <= data;
        w_sel           <= sel;
        reg_write       <= !wr_en;
        rd              <= rd_val;
        exp_rd          <= rd_val;
        chk_wdata       <= check && !mis;
        exp_wdata       <= expected;
        exp_mal_l       <= rd_en && mis;
        exp_mal_s       <= wr_en && mis;
        exp_reg_write_m <= !wr_en && !(rd_en && mis);
        if (v && (rd_en || wr_en) && !mis) begin
            acc_id <= acc_id + 1;
        end
        // Hold the request until the bus lets go
        @(negedge CLK);
        while (mem_busy) begin
            @(negedge CLK);
        end
    endtask

    task automatic store_op(input rv32_types_pkg::ls_width_t w, input rv32_types_pkg::word_t addr,
                            input rv32_types_pkg::word_t data);
        if (!misaligned_access(w, addr[1:0])) begin
            shadow_store(w, addr[9:0], data);
        end
        drive_op(1'b1, 1'b0, 1'b1, w, addr, data, mem_sys_pkg::WSEL_LOAD, 1'b0, '0);
    endtask

    task automatic load_op(input rv32_types_pkg::ls_width_t w, input rv32_types_pkg::word_t addr);
        drive_op(1'b1, 1'b1, 1'b0, w, addr, $urandom, mem_sys_pkg::WSEL_LOAD, 1'b1,
                 expected_load(w, addr[9:0]));
    endtask

    a_wdata: assert property (@(posedge CLK) disable iff (!nRST)
        (chk_wdata && !mem_busy) |-> (reg_wdata == exp_wdata))
        else report_value("reg_wdata", $sampled(exp_wdata), $sampled(reg_wdata));

    a_rd_m: assert property (@(posedge CLK) disable iff (!nRST) rd_m == exp_rd)
        else report_value("rd_m", 32'($sampled(exp_rd)), 32'($sampled(rd_m)));

    a_mal_l: assert property (@(posedge CLK) disable iff (!nRST) mal_l == exp_mal_l)
        else report_value("mal_l", 32'($sampled(exp_mal_l)), 32'($sampled(mal_l)));

    a_mal_s: assert property (@(posedge CLK) disable iff (!nRST) mal_s == exp_mal_s)
        else report_value("mal_s", 32'($sampled(exp_mal_s)), 32'($sampled(mal_s)));

    a_reg_write_m: assert property (@(posedge CLK) disable iff (!nRST)
        reg_write_m == exp_reg_write_m)
        else report_value("reg_write_m", 32'($sampled(exp_reg_write_m)),
                          32'($sampled(reg_write_m)));

    // Busy in the first cycle of an access, clear in the second
    a_busy_first: assert property (@(posedge CLK) disable iff (!nRST)
        (acc_id != $past(acc_id)) |-> mem_busy)
        else report_value("mem_busy", 32'h1, 32'($sampled(mem_busy)));

    a_busy_second: assert property (@(posedge CLK) disable iff (!nRST)
        ($past(acc_id) != $past(acc_id, 2)) |-> !mem_busy)
        else report_value("mem_busy", 32'h0, 32'($sampled(mem_busy)));

    a_idle_no_busy: assert property (@(posedge CLK) disable iff (!nRST)
        (!(valid && (dren || dwen)) || mal_l || mal_s) |-> !mem_busy)
        else stop_on_failure("mem_busy rose without an aligned bus request");

    a_stall_on_fence: assert property (@(posedge CLK) disable iff (!nRST)
        $rose(ifence) |-> fence_stall)
        else stop_on_failure("fence_stall did not rise together with ifence");

    a_no_stall_idle: assert property (@(posedge CLK) disable iff (!nRST)
        !ifence |-> !fence_stall)
        else report_value("fence_stall", 32'h0, 32'($sampled(fence_stall)));

    a_stall_min: assert property (@(posedge CLK) disable iff (!nRST)
        $fell(fence_stall) |-> (stall_run >= DFLUSH))
        else stop_on_failure($sformatf("fence stall ended after only %0d cycles",
                                       $sampled(stall_run)));

    a_stall_max: assert property (@(posedge CLK) disable iff (!nRST)
        fence_stall |-> (stall_run < DFLUSH + 6))
        else stop_on_failure("fence stall lasted longer than the flush bound");

    initial begin
        #(RUN_CYCLES * CLK_PERIOD * 3 / 2);
        stop_on_failure("watchdog expired before the tests finished");
    end

    initial begin
        rv32_types_pkg::word_t base;
        rv32_types_pkg::word_t alu_val;
        rv32_types_pkg::word_t pc_val;
        rv32_types_pkg::word_t imm_val;
        void'($urandom(32'hc89a4ebf));
        pc_val    = $urandom;
        imm_val   = $urandom & 32'hffff_f000;
        nRST      = 1'b0;
        valid     = 1'b0;
        dren      = 1'b0;
        dwen      = 1'b0;
        width     = rv32_types_pkg::LW;
        alu_out   = '0;
        store_src = '0;
        pc4       = pc_val;
        imm_u     = imm_val;
        w_sel     = mem_sys_pkg::WSEL_LOAD;
        rd        = '0;
        reg_write = 1'b0;
        ifence    = 1'b0;
        repeat (4) @(posedge CLK);
        nRST <= 1'b1;
        repeat (3) @(posedge CLK);

        // Whole words at random addresses
        repeat (WORD_ROUNDS) begin
            base = $urandom & 32'h0000_03fc;
            store_op(rv32_types_pkg::LW, base, $urandom);
            load_op(rv32_types_pkg::LW, base);
        end

        // Every byte and halfword lane, both signs
        repeat (2) begin
            base = $urandom & 32'h0000_03fc;
            store_op(rv32_types_pkg::LW, base, $urandom);
            for (int o = 0; o < 4; o++) begin
                store_op(rv32_types_pkg::LB, base + o, $urandom | (o[0] ? 32'h80 : 32'h0));
                load_op(rv32_types_pkg::LB, base + o);
                load_op(rv32_types_pkg::LBU, base + o);
            end
            load_op(rv32_types_pkg::LW, base);
            for (int o = 0; o < 4; o += 2) begin
                store_op(rv32_types_pkg::LH, base + o, $urandom | (o[1] ? 32'h8000 : 32'h0));
                load_op(rv32_types_pkg::LH, base + o);
                load_op(rv32_types_pkg::LHU, base + o);
            end
            load_op(rv32_types_pkg::LW, base);
        end

        // Misaligned accesses leave the word alone
        base = $urandom & 32'h0000_03fc;
        store_op(rv32_types_pkg::LW, base, $urandom);
        for (int o = 1; o < 4; o++) begin
            load_op(rv32_types_pkg::LW, base + o);
            store_op(rv32_types_pkg::LW, base + o, $urandom);
        end
        for (int o = 1; o < 4; o += 2) begin
            load_op(rv32_types_pkg::LH, base + o);
            load_op(rv32_types_pkg::LHU, base + o);
            store_op(rv32_types_pkg::LH, base + o, $urandom);
        end
        load_op(rv32_types_pkg::LW, base);

        // Writeback sources other than the load path
        alu_val = $urandom;
        drive_op(1'b0, 1'b0, 1'b0, rv32_types_pkg::LW, alu_val, '0, mem_sys_pkg::WSEL_PC4,
                 1'b1, pc_val);
        drive_op(1'b0, 1'b0, 1'b0, rv32_types_pkg::LW, alu_val, '0, mem_sys_pkg::WSEL_IMMU,
                 1'b1, imm_val);
        drive_op(1'b0, 1'b0, 1'b0, rv32_types_pkg::LW, alu_val, '0, mem_sys_pkg::WSEL_ALU,
                 1'b1, alu_val);
        for (int c = 4; c < 8; c++) begin
            drive_op(1'b0, 1'b0, 1'b0, rv32_types_pkg::LW, alu_val, '0, mem_sys_pkg::wsel_t'(c),
                     1'b1, '0);
        end

        // Two instruction fences
        repeat (2) begin
            @(posedge CLK);
            ifence <= 1'b1;
            @(negedge CLK);
            while (fence_stall) begin
                @(negedge CLK);
            end
            @(posedge CLK);
            ifence <= 1'b0;
            repeat (3) @(posedge CLK);
        end

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic                      valid,
    input  logic                      dren,
    input  logic                      dwen,
    input  rv32_types_pkg::ls_width_t width,
    input  rv32_types_pkg::word_t     alu_out,
    input  rv32_types_pkg::word_t     store_src,
    input  rv32_types_pkg::word_t     pc4,
    input  rv32_types_pkg::word_t     imm_u,
    input  mem_sys_pkg::wsel_t        w_sel,
    input  rv32_types_pkg::reg_addr_t rd,
    input  logic                      reg_write,
    input  logic                      ifence,
    output logic                      mem_busy,
    output logic                      fence_stall,
    output logic                      mal_l,
    output logic                      mal_s,
    output rv32_types_pkg::word_t     reg_wdata,
    output rv32_types_pkg::reg_addr_t rd_m,
    output logic                      reg_write_m
);

    logic icache_req;
    logic icache_ack;
    logic dcache_req;
    logic dcache_ack;

    dbus_if dbus ();

    mem_stage u_stage (
        .valid       (valid),
        .dren        (dren),
        .dwen        (dwen),
        .width       (width),
        .alu_out     (alu_out),
        .store_src   (store_src),
        .pc4         (pc4),
        .imm_u       (imm_u),
        .w_sel       (w_sel),
        .rd          (rd),
        .reg_write   (reg_write),
        .bus         (dbus.master),
        .mem_busy    (mem_busy),
        .mal_l       (mal_l),
        .mal_s       (mal_s),
        .reg_wdata   (reg_wdata),
        .rd_m        (rd_m),
        .reg_write_m (reg_write_m)
    );

    data_ram u_ram (
        .CLK  (CLK),
        .nRST (nRST),
        .bus  (dbus.slave)
    );

    fence_ctrl u_fence (
        .CLK         (CLK),
        .nRST        (nRST),
        .ifence      (ifence),
        .icache_req  (icache_req),
        .icache_ack  (icache_ack),
        .dcache_req  (dcache_req),
        .dcache_ack  (dcache_ack),
        .fence_stall (fence_stall)
    );

    // Cache stand-ins with their own flush lengths
    flush_timer u_iflush (
        .CLK      (CLK),
        .nRST     (nRST),
        .req      (icache_req),
        .duration (mem_sys_pkg::ICACHE_FLUSH_CYCLES),
        .ack      (icache_ack)
    );

    flush_timer u_dflush (
        .CLK      (CLK),
        .nRST     (nRST),
        .req      (dcache_req),
        .duration (mem_sys_pkg::DCACHE_FLUSH_CYCLES),
        .ack      (dcache_ack)
    );

endmodule

`default_nettype wire

//--- hw/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  logic                      valid,
    input  logic                      dren,
    input  logic                      dwen,
    input  rv32_types_pkg::ls_width_t width,
    input  rv32_types_pkg::word_t     alu_out,
    input  rv32_types_pkg::word_t     store_src,
    input  rv32_types_pkg::word_t     pc4,
    input  rv32_types_pkg::word_t     imm_u,
    input  mem_sys_pkg::wsel_t        w_sel,
    input  rv32_types_pkg::reg_addr_t rd,
    input  logic                      reg_write,
    dbus_if.master                    bus,
    output logic                      mem_busy,
    output logic                      mal_l,
    output logic                      mal_s,
    output rv32_types_pkg::word_t     reg_wdata,
    output rv32_types_pkg::reg_addr_t rd_m,
    output logic                      reg_write_m
);

    rv32_types_pkg::byte_en_t lane_en;
    rv32_types_pkg::word_t    lane_wdata;
    rv32_types_pkg::word_t    load_data;
    logic                     misaligned;

    lane_unit u_lanes (
        .width      (width),
        .offset     (alu_out[1:0]),
        .store_data (store_src),
        .byte_en    (lane_en),
        .wdata      (lane_wdata),
        .misaligned (misaligned)
    );

    load_extender u_ext (
        .rdata   (bus.rdata),
        .width   (width),
        .offset  (alu_out[1:0]),
        .ext_out (load_data)
    );

    // Misaligned accesses never reach the bus
    assign bus.ren     = valid & dren & ~misaligned;
    assign bus.wen     = valid & dwen & ~misaligned;
    assign bus.addr    = alu_out;
    assign bus.byte_en = lane_en;
    assign bus.wdata   = lane_wdata;

    assign mem_busy = bus.busy;
    assign mal_l    = valid & dren & misaligned;
    assign mal_s    = valid & dwen & misaligned;

    always_comb begin
        case (w_sel)
            mem_sys_pkg::WSEL_LOAD: reg_wdata = load_data;
            mem_sys_pkg::WSEL_PC4:  reg_wdata = pc4;
            mem_sys_pkg::WSEL_IMMU: reg_wdata = imm_u;
            mem_sys_pkg::WSEL_ALU:  reg_wdata = alu_out;
            default:                reg_wdata = '0;
        endcase
    end

    assign rd_m        = rd;
    // No register write for a trapped load
    assign reg_write_m = reg_write & ~mal_l;

endmodule

`default_nettype wire

//--- hw/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram (
    input  logic  CLK,
    input  logic  nRST,
    dbus_if.slave bus
);

    rv32_types_pkg::word_t mem [mem_sys_pkg::MEM_WORDS];

    mem_sys_pkg::mem_index_t idx;
    logic req;
    logic served;

    assign req = bus.ren | bus.wen;
    assign idx = bus.addr[9:2];

    // Busy only in the first cycle of a request
    assign bus.busy  = req & ~served;
    assign bus.rdata = mem[idx];

    // Toggles once per request so back-to-back accesses restart cleanly
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            served <= 1'b0;
        end else begin
            served <= req & ~served;
        end
    end

    // Commit on the edge ending the second cycle
    always_ff @(posedge CLK) begin
        if (bus.wen && served) begin
            for (int i = 0; i < 4; i++) begin
                if (bus.byte_en[i]) begin
                    mem[idx][8*i +: 8] <= bus.wdata[8*i +: 8];
                end
            end
        end
    end

    a_no_read_and_write: assert property (@(posedge CLK) disable iff (!nRST)
        !(bus.ren && bus.wen));

endmodule

`default_nettype wire

//--- hw/flush_timer.sv
`timescale 1ns/1ps
`default_nettype none

module flush_timer (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic                      req,
    input  mem_sys_pkg::flush_count_t duration,
    output logic                      ack
);

    mem_sys_pkg::flush_count_t count;
    mem_sys_pkg::flush_count_t count_inc;

    assign count_inc = count + 4'd1;

    // Stand-in for a cache walking its lines
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count <= '0;
            ack   <= 1'b0;
        end else if (!req) begin
            count <= '0;
            ack   <= 1'b0;
        end else if (!ack) begin
            count <= count_inc;
            if (count_inc == duration) begin
                ack <= 1'b1;
            end
        end
    end

    // Four-phase return to zero
    a_ack_falls_after_req: assert property (@(posedge CLK) disable iff (!nRST)
        $fell(ack) |-> !$past(req));

endmodule

`default_nettype wire

//--- hw/fence_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fence_ctrl (
    input  logic CLK,
    input  logic nRST,
    input  logic ifence,
    output logic icache_req,
    input  logic icache_ack,
    output logic dcache_req,
    input  logic dcache_ack,
    output logic fence_stall
);

    mem_sys_pkg::fence_state_t state;
    logic ifence_q;
    logic ifence_rise;
    logic icache_req_nxt;
    logic dcache_req_nxt;

    assign ifence_rise = ifence & ~ifence_q;

    // Each req drops the cycle after its ack shows up
    assign icache_req_nxt = icache_req & ~icache_ack;
    assign dcache_req_nxt = dcache_req & ~dcache_ack;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state      <= mem_sys_pkg::FENCE_IDLE;
            ifence_q   <= 1'b0;
            icache_req <= 1'b0;
            dcache_req <= 1'b0;
        end else begin
            ifence_q <= ifence;
            case (state)
                mem_sys_pkg::FENCE_IDLE: begin
                    if (ifence_rise) begin
                        icache_req <= 1'b1;
                        dcache_req <= 1'b1;
                        state      <= mem_sys_pkg::FENCE_REQ;
                    end
                end
                mem_sys_pkg::FENCE_REQ: begin
                    icache_req <= icache_req_nxt;
                    dcache_req <= dcache_req_nxt;
                    if (!icache_req_nxt && !dcache_req_nxt) begin
                        state <= mem_sys_pkg::FENCE_RELEASE;
                    end
                end
                mem_sys_pkg::FENCE_RELEASE: begin
                    // Wait for both timers to finish the handshake
                    if (!icache_ack && !dcache_ack) begin
                        state <= mem_sys_pkg::FENCE_DONE;
                    end
                end
                default: begin
                    if (!ifence) begin
                        state <= mem_sys_pkg::FENCE_IDLE;
                    end
                end
            endcase
        end
    end

    assign fence_stall = ifence && (state != mem_sys_pkg::FENCE_DONE);

    a_req_only_in_req_state: assert property (@(posedge CLK) disable iff (!nRST)
        ($rose(icache_req) || $rose(dcache_req)) |-> (state == mem_sys_pkg::FENCE_REQ));

    a_iack_needs_req: assert property (@(posedge CLK) disable iff (!nRST)
        $rose(icache_ack) |-> icache_req);

    a_dack_needs_req: assert property (@(posedge CLK) disable iff (!nRST)
        $rose(dcache_ack) |-> dcache_req);

endmodule

`default_nettype wire

//--- hw/load_extender.sv
`timescale 1ns/1ps
`default_nettype none

module load_extender (
    input  rv32_types_pkg::word_t     rdata,
    input  rv32_types_pkg::ls_width_t width,
    input  logic [1:0]                offset,
    output rv32_types_pkg::word_t     ext_out
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // Little-endian lane pick
    always_comb begin
        case (offset)
            2'b00:   sel_byte = rdata[7:0];
            2'b01:   sel_byte = rdata[15:8];
            2'b10:   sel_byte = rdata[23:16];
            default: sel_byte = rdata[31:24];
        endcase
    end

    assign sel_half = offset[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (width)
            rv32_types_pkg::LB:  ext_out = {{24{sel_byte[7]}}, sel_byte};
            rv32_types_pkg::LBU: ext_out = {24'h0, sel_byte};
            rv32_types_pkg::LH:  ext_out = {{16{sel_half[15]}}, sel_half};
            rv32_types_pkg::LHU: ext_out = {16'h0, sel_half};
            default:             ext_out = rdata;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/lane_unit.sv
`timescale 1ns/1ps
`default_nettype none

module lane_unit (
    input  rv32_types_pkg::ls_width_t width,
    input  logic [1:0]                offset,
    input  rv32_types_pkg::word_t     store_data,
    output rv32_types_pkg::byte_en_t  byte_en,
    output rv32_types_pkg::word_t     wdata,
    output logic                      misaligned
);

    // Lane enables per width and offset
    always_comb begin
        byte_en = 4'b0000;
        case (width)
            rv32_types_pkg::LB, rv32_types_pkg::LBU: begin
                byte_en = 4'b0001 << offset;
            end
            rv32_types_pkg::LH, rv32_types_pkg::LHU: begin
                case (offset)
                    2'b00:   byte_en = 4'b0011;
                    2'b10:   byte_en = 4'b1100;
                    default: byte_en = 4'b0000;
                endcase
            end
            rv32_types_pkg::LW: begin
                byte_en = (offset == 2'b00) ? 4'b1111 : 4'b0000;
            end
            default: byte_en = 4'b0000;
        endcase
    end

    // Store data copied to every lane it could land in
    always_comb begin
        case (width)
            rv32_types_pkg::LB, rv32_types_pkg::LBU: wdata = {4{store_data[7:0]}};
            rv32_types_pkg::LH, rv32_types_pkg::LHU: wdata = {2{store_data[15:0]}};
            default:                                 wdata = store_data;
        endcase
    end

    always_comb begin
        case (width)
            rv32_types_pkg::LW:                      misaligned = (offset != 2'b00);
            rv32_types_pkg::LH, rv32_types_pkg::LHU: misaligned = offset[0];
            default:                                 misaligned = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/dbus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dbus_if;

    logic                     ren;
    logic                     wen;
    rv32_types_pkg::word_t    addr;
    rv32_types_pkg::byte_en_t byte_en;
    rv32_types_pkg::word_t    wdata;
    rv32_types_pkg::word_t    rdata;
    logic                     busy;

    modport master (
        output ren, wen, addr, byte_en, wdata,
        input  rdata, busy
    );

    modport slave (
        input  ren, wen, addr, byte_en, wdata,
        output rdata, busy
    );

endinterface

`default_nettype wire

//--- hw/mem_sys_pkg.sv
`default_nettype none

package mem_sys_pkg;

    // Scratchpad depth in words
    localparam int MEM_WORDS = 256;
    typedef logic [7:0] mem_index_t;

    // Flush durations of the cache stand-ins
    typedef logic [3:0] flush_count_t;
    localparam flush_count_t ICACHE_FLUSH_CYCLES = 4'd6;
    localparam flush_count_t DCACHE_FLUSH_CYCLES = 4'd11;

    // Writeback source select, other codes give zero
    typedef logic [2:0] wsel_t;
    localparam wsel_t WSEL_LOAD = 3'd0;
    localparam wsel_t WSEL_PC4  = 3'd1;
    localparam wsel_t WSEL_IMMU = 3'd2;
    localparam wsel_t WSEL_ALU  = 3'd3;

    // Instruction fence sequencer
    typedef enum logic [1:0] {
        FENCE_IDLE,
        FENCE_REQ,
        FENCE_RELEASE,
        FENCE_DONE
    } fence_state_t;

endpackage

`default_nettype wire

//--- hw/rv32_types_pkg.sv
`default_nettype none

package rv32_types_pkg;

    // Data or address word
    typedef logic [31:0] word_t;

    // One enable per byte lane
    typedef logic [3:0] byte_en_t;

    typedef logic [4:0] reg_addr_t;

    // Load/store width, funct3 encoding
    typedef logic [2:0] ls_width_t;

    localparam ls_width_t LB  = 3'd0;
    localparam ls_width_t LH  = 3'd1;
    localparam ls_width_t LW  = 3'd2;
    localparam ls_width_t LBU = 3'd4;
    localparam ls_width_t LHU = 3'd5;

endpackage

`default_nettype wire
